/* Bender.yml */
package:
  name: id_stage

sources:
  - include_dirs:
      - design
    files:
      - design/id_isa_pkg.sv
      - design/id_pipe_pkg.sv
      - design/id_decoder.sv
      - design/id_rf_fwd.sv
      - design/id_issue_ctrl.sv
      - design/id_stage.sv

  - target: test
    include_dirs:
      - design
      - test
    files:
      - test/tb_id_stage.sv

/* design/id_decoder.sv */
`timescale 1ns/100ps
`include "id_defines.svh"

module id_decoder (
  input  logic [`ID_XLEN-1:0] instr_i,
  output id_isa_pkg::decoded_t decoded_o,
  output logic [`ID_XLEN-1:0] imm_o
);

  import id_isa_pkg::*;

  // Instruction fields
  opcode_e             opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`ID_XLEN-1:0] imm_i_type;
  logic [`ID_XLEN-1:0] imm_s_type;
  logic [`ID_XLEN-1:0] imm_u_type;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  ////////////////////////////////////////
  // Immediate generation
  ////////////////////////////////////////

  // Sign bit always sits in bit 31
  assign imm_i_type = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  always_comb begin
    unique case (opcode)
      OPCODE_OP_IMM,
      OPCODE_LOAD:   imm_o = imm_i_type;
      OPCODE_STORE:  imm_o = imm_s_type;
      OPCODE_LUI,
      OPCODE_AUIPC:  imm_o = imm_u_type;
      // No immediate in use, word step as neutral value
      default:       imm_o = `ID_XLEN'(`ID_ADDR_INCR);
    endcase
  end

  ////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////

  always_comb begin
    decoded_o          = '0;
    decoded_o.alu_op   = ALU_ADD;
    decoded_o.op_a_sel = OP_A_REG_A;
    decoded_o.op_b_sel = OP_B_REG_B;
    decoded_o.lsu_type = LSU_WORD;
    decoded_o.rf_waddr = instr_i[11:7];

    unique case (opcode)
      OPCODE_OP_IMM: begin
        decoded_o.rf_we    = 1'b1;
        decoded_o.rf_ren_a = 1'b1;
        decoded_o.op_b_sel = OP_B_IMM;
        unique case (funct3)
          3'b000: decoded_o.alu_op = ALU_ADD;
          3'b010: decoded_o.alu_op = ALU_SLT;
          3'b011: decoded_o.alu_op = ALU_SLTU;
          3'b100: decoded_o.alu_op = ALU_XOR;
          3'b110: decoded_o.alu_op = ALU_OR;
          3'b111: decoded_o.alu_op = ALU_AND;
          3'b001: begin
            decoded_o.alu_op  = ALU_SLL;
            decoded_o.illegal = (funct7 != 7'b000_0000);
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            if (funct7 == 7'b000_0000) begin
              decoded_o.alu_op = ALU_SRL;
            end else if (funct7 == 7'b010_0000) begin
              decoded_o.alu_op = ALU_SRA;
            end else begin
              decoded_o.illegal = 1'b1;
            end
          end
        endcase
      end

      OPCODE_OP: begin
        decoded_o.rf_we    = 1'b1;
        decoded_o.rf_ren_a = 1'b1;
        decoded_o.rf_ren_b = 1'b1;
        unique case ({funct7, funct3})
          {7'b000_0000, 3'b000}: decoded_o.alu_op = ALU_ADD;
          {7'b010_0000, 3'b000}: decoded_o.alu_op = ALU_SUB;
          {7'b000_0000, 3'b001}: decoded_o.alu_op = ALU_SLL;
          {7'b000_0000, 3'b010}: decoded_o.alu_op = ALU_SLT;
          {7'b000_0000, 3'b011}: decoded_o.alu_op = ALU_SLTU;
          {7'b000_0000, 3'b100}: decoded_o.alu_op = ALU_XOR;
          {7'b000_0000, 3'b101}: decoded_o.alu_op = ALU_SRL;
          {7'b010_0000, 3'b101}: decoded_o.alu_op = ALU_SRA;
          {7'b000_0000, 3'b110}: decoded_o.alu_op = ALU_OR;
          {7'b000_0000, 3'b111}: decoded_o.alu_op = ALU_AND;
          default:               decoded_o.illegal = 1'b1;
        endcase
      end

      // Upper immediates go through the adder with A forced
      OPCODE_LUI: begin
        decoded_o.rf_we    = 1'b1;
        decoded_o.op_a_sel = OP_A_ZERO;
        decoded_o.op_b_sel = OP_B_IMM;
      end

      OPCODE_AUIPC: begin
        decoded_o.rf_we    = 1'b1;
        decoded_o.op_a_sel = OP_A_CURRPC;
        decoded_o.op_b_sel = OP_B_IMM;
      end

      // Address is rs1 plus offset in both memory cases
      OPCODE_LOAD: begin
        decoded_o.rf_we        = 1'b1;
        decoded_o.rf_ren_a     = 1'b1;
        decoded_o.op_b_sel     = OP_B_IMM;
        decoded_o.lsu_req      = 1'b1;
        decoded_o.lsu_sign_ext = ~funct3[2];
        unique case (funct3)
          3'b000, 3'b100: decoded_o.lsu_type = LSU_BYTE;
          3'b001, 3'b101: decoded_o.lsu_type = LSU_HALF;
          3'b010:         decoded_o.lsu_type = LSU_WORD;
          default:        decoded_o.illegal  = 1'b1;
        endcase
      end

      OPCODE_STORE: begin
        decoded_o.rf_ren_a = 1'b1;
        decoded_o.rf_ren_b = 1'b1;
        decoded_o.op_b_sel = OP_B_IMM;
        decoded_o.lsu_req  = 1'b1;
        decoded_o.lsu_we   = 1'b1;
        unique case (funct3)
          3'b000:  decoded_o.lsu_type = LSU_BYTE;
          3'b001:  decoded_o.lsu_type = LSU_HALF;
          3'b010:  decoded_o.lsu_type = LSU_WORD;
          default: decoded_o.illegal  = 1'b1;
        endcase
      end

      default: decoded_o.illegal = 1'b1;
    endcase

    // Unknown encodings must have no side effects
    if (decoded_o.illegal) begin
      decoded_o.rf_we   = 1'b0;
      decoded_o.lsu_req = 1'b0;
    end
  end

  // Illegal word never reaches the LSU
  illegal_no_lsu_a: assert final (!(decoded_o.illegal && decoded_o.lsu_req));

endmodule

/* design/id_defines.svh */
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Data word width of the core
`define ID_XLEN 32

// Register file address width, 32 registers
`define ID_REG_AW 5

////////////////////////////////////////
// Address arithmetic
////////////////////////////////////////

// Word step, used as the fallback operand B immediate
`define ID_ADDR_INCR 4

`endif

/* design/id_isa_pkg.sv */
`include "id_defines.svh"

package id_isa_pkg;

  ////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////

  // Only ALU and memory opcodes are decoded
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37
  } opcode_e;

  ////////////////////////////////////////
  // Execute controls
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  // Access size as seen by the LSU
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  // Operand A source
  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_CURRPC,
    OP_A_ZERO
  } op_a_sel_e;

  // Operand B source
  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  // Everything the decoder extracts from one instruction word
  typedef struct packed {
    alu_op_e                  alu_op;
    op_a_sel_e                op_a_sel;
    op_b_sel_e                op_b_sel;
    logic                     rf_we;
    logic [`ID_REG_AW-1:0]    rf_waddr;
    logic                     rf_ren_a;
    logic                     rf_ren_b;
    logic                     lsu_req;
    logic                     lsu_we;
    lsu_type_e                lsu_type;
    logic                     lsu_sign_ext;
    logic                     illegal;
  } decoded_t;

endpackage

/* design/id_issue_ctrl.sv */
`timescale 1ns/100ps
`include "id_defines.svh"

module id_issue_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 instr_valid_i,
  input  logic [`ID_XLEN-1:0]  pc_i,
  input  id_isa_pkg::decoded_t decoded_i,
  input  logic [`ID_XLEN-1:0]  imm_i,
  input  logic [`ID_XLEN-1:0]  rdata_a_fwd_i,
  input  logic [`ID_XLEN-1:0]  rdata_b_fwd_i,
  input  logic                 match_a_i,
  input  logic                 match_b_i,
  input  logic                 mem_busy_i,
  input  logic                 outstanding_load_i,
  input  logic                 lsu_req_done_i,
  output id_pipe_pkg::ex_req_t ex_req_o,
  output logic                 id_in_ready_o,
  output logic                 illegal_insn_o
);

  import id_isa_pkg::*;
  import id_pipe_pkg::*;

  id_fsm_e             id_fsm_q;
  id_fsm_e             id_fsm_d;
  logic                stall_ld_hz;
  logic                instr_executing;
  logic                mem_done;
  logic                instr_done;
  logic [`ID_XLEN-1:0] operand_a;

  ////////////////////////////////////////
  // Hazards and completion
  ////////////////////////////////////////

  // Reading a register the pending load will write
  assign stall_ld_hz = outstanding_load_i &
                       ((match_a_i & decoded_i.rf_ren_a) | (match_b_i & decoded_i.rf_ren_b));

  assign instr_executing = instr_valid_i & ~stall_ld_hz & ~mem_busy_i;

  // Memory op finishes once the LSU takes it
  assign mem_done   = ~decoded_i.lsu_req | lsu_req_done_i;
  assign instr_done = instr_executing & mem_done;

  ////////////////////////////////////////
  // Issue FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_fsm_q <= FIRST_CYCLE;
    end else begin
      id_fsm_q <= id_fsm_d;
    end
  end

  always_comb begin
    id_fsm_d = id_fsm_q;
    if (instr_executing) begin
      unique case (id_fsm_q)
        FIRST_CYCLE: begin
          // Wait here only if acceptance is not immediate
          if (decoded_i.lsu_req && !lsu_req_done_i) begin
            id_fsm_d = MULTI_CYCLE;
          end
        end
        MULTI_CYCLE: begin
          if (mem_done) begin
            id_fsm_d = FIRST_CYCLE;
          end
        end
        default: id_fsm_d = FIRST_CYCLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Operands and request
  ////////////////////////////////////////

  always_comb begin
    unique case (decoded_i.op_a_sel)
      OP_A_REG_A:  operand_a = rdata_a_fwd_i;
      OP_A_CURRPC: operand_a = pc_i;
      default:     operand_a = '0;
    endcase
  end

  assign ex_req_o.alu_op       = decoded_i.alu_op;
  assign ex_req_o.operand_a    = operand_a;
  assign ex_req_o.operand_b    = (decoded_i.op_b_sel == OP_B_IMM) ? imm_i : rdata_b_fwd_i;
  // Write only in the completing cycle
  assign ex_req_o.rf_we        = decoded_i.rf_we & instr_done;
  assign ex_req_o.rf_waddr     = decoded_i.rf_waddr;
  assign ex_req_o.lsu_req      = decoded_i.lsu_req & instr_executing;
  assign ex_req_o.lsu_we       = decoded_i.lsu_we;
  assign ex_req_o.lsu_type     = decoded_i.lsu_type;
  assign ex_req_o.lsu_sign_ext = decoded_i.lsu_sign_ext;
  // Store data from rs2
  assign ex_req_o.lsu_wdata    = rdata_b_fwd_i;

  assign id_in_ready_o  = instr_done;
  assign illegal_insn_o = instr_valid_i & decoded_i.illegal;

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // No second request once the LSU accepted
  no_req_after_done_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (id_fsm_q == MULTI_CYCLE && instr_done) |=>
      !(id_fsm_q == MULTI_CYCLE && ex_req_o.lsu_req)
  );

  ready_needs_valid_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    id_in_ready_o |-> instr_valid_i
  );

endmodule

/* design/id_pipe_pkg.sv */
`include "id_defines.svh"

package id_pipe_pkg;

  ////////////////////////////////////////
  // Writeback feedback
  ////////////////////////////////////////

  // Register write in flight plus memory status of the writeback stage
  typedef struct packed {
    logic [`ID_REG_AW-1:0] waddr;
    logic                  write;
    logic [`ID_XLEN-1:0]   wdata;
    logic                  outstanding_load;
    logic                  outstanding_store;
  } wb_info_t;

  ////////////////////////////////////////
  // Request towards execute
  ////////////////////////////////////////

  typedef struct packed {
    id_isa_pkg::alu_op_e   alu_op;
    logic [`ID_XLEN-1:0]   operand_a;
    logic [`ID_XLEN-1:0]   operand_b;
    logic                  rf_we;
    logic [`ID_REG_AW-1:0] rf_waddr;
    logic                  lsu_req;
    logic                  lsu_we;
    id_isa_pkg::lsu_type_e lsu_type;
    logic                  lsu_sign_ext;
    logic [`ID_XLEN-1:0]   lsu_wdata;
  } ex_req_t;

  // Issue FSM, memory instructions may linger in MULTI_CYCLE
  typedef enum logic {
    FIRST_CYCLE,
    MULTI_CYCLE
  } id_fsm_e;

endpackage

/* design/id_rf_fwd.sv */
`timescale 1ns/100ps
`include "id_defines.svh"

module id_rf_fwd (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`ID_XLEN-1:0]    instr_i,
  // Register file read ports
  output logic [`ID_REG_AW-1:0]  rf_raddr_a_o,
  output logic [`ID_REG_AW-1:0]  rf_raddr_b_o,
  input  logic [`ID_XLEN-1:0]    rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0]    rf_rdata_b_i,
  // Writeback feedback
  input  id_pipe_pkg::wb_info_t  wb_info_i,
  input  logic                   lsu_resp_valid_i,
  // Towards issue control
  output logic [`ID_XLEN-1:0]    rdata_a_fwd_o,
  output logic [`ID_XLEN-1:0]    rdata_b_fwd_o,
  output logic                   match_a_o,
  output logic                   match_b_o,
  output logic                   mem_busy_o
);

  // rs1 and rs2 fields, read whether used or not
  assign rf_raddr_a_o = instr_i[19:15];
  assign rf_raddr_b_o = instr_i[24:20];

  ////////////////////////////////////////
  // Writeback match and bypass
  ////////////////////////////////////////

  // x0 never matches
  assign match_a_o = (wb_info_i.waddr == rf_raddr_a_o) & |rf_raddr_a_o;
  assign match_b_o = (wb_info_i.waddr == rf_raddr_b_o) & |rf_raddr_b_o;

  // Load data is too late for bypass, that case stalls instead
  assign rdata_a_fwd_o = (match_a_o & wb_info_i.write) ? wb_info_i.wdata : rf_rdata_a_i;
  assign rdata_b_fwd_o = (match_b_o & wb_info_i.write) ? wb_info_i.wdata : rf_rdata_b_i;

  // Access in flight that does not resolve this cycle
  assign mem_busy_o = (wb_info_i.outstanding_load | wb_info_i.outstanding_store) &
                      ~lsu_resp_valid_i;

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // Reading x0 always returns the register file value
  x0_a_not_fwd_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (rf_raddr_a_o == '0) |-> (rdata_a_fwd_o == rf_rdata_a_i)
  );

  x0_b_not_fwd_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (rf_raddr_b_o == '0) |-> (rdata_b_fwd_o == rf_rdata_b_i)
  );

endmodule

/* design/id_stage.sv */
`timescale 1ns/100ps
`include "id_defines.svh"

module id_stage (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Fetch side
  input  logic                  instr_valid_i,
  input  logic [`ID_XLEN-1:0]   instr_rdata_i,
  input  logic [`ID_XLEN-1:0]   pc_i,
  // Register file
  output logic [`ID_REG_AW-1:0] rf_raddr_a_o,
  output logic [`ID_REG_AW-1:0] rf_raddr_b_o,
  input  logic [`ID_XLEN-1:0]   rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0]   rf_rdata_b_i,
  // Writeback and LSU status
  input  id_pipe_pkg::wb_info_t wb_info_i,
  input  logic                  lsu_req_done_i,
  input  logic                  lsu_resp_valid_i,
  // Execute side
  output id_pipe_pkg::ex_req_t  ex_req_o,
  output logic                  id_in_ready_o,
  output logic                  illegal_insn_o
);

  import id_isa_pkg::*;

  decoded_t            decoded;
  logic [`ID_XLEN-1:0] imm;
  logic [`ID_XLEN-1:0] rdata_a_fwd;
  logic [`ID_XLEN-1:0] rdata_b_fwd;
  logic                match_a;
  logic                match_b;
  logic                mem_busy;

  ////////////////////////////////////////
  // Decode and register read in parallel
  ////////////////////////////////////////

  id_decoder decoder_i (
    .instr_i   (instr_rdata_i),
    .decoded_o (decoded),
    .imm_o     (imm)
  );

  id_rf_fwd rf_fwd_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_i          (instr_rdata_i),
    .rf_raddr_a_o     (rf_raddr_a_o),
    .rf_raddr_b_o     (rf_raddr_b_o),
    .rf_rdata_a_i     (rf_rdata_a_i),
    .rf_rdata_b_i     (rf_rdata_b_i),
    .wb_info_i        (wb_info_i),
    .lsu_resp_valid_i (lsu_resp_valid_i),
    .rdata_a_fwd_o    (rdata_a_fwd),
    .rdata_b_fwd_o    (rdata_b_fwd),
    .match_a_o        (match_a),
    .match_b_o        (match_b),
    .mem_busy_o       (mem_busy)
  );

  // Issue control merges both paths
  id_issue_ctrl issue_ctrl_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .instr_valid_i      (instr_valid_i),
    .pc_i               (pc_i),
    .decoded_i          (decoded),
    .imm_i              (imm),
    .rdata_a_fwd_i      (rdata_a_fwd),
    .rdata_b_fwd_i      (rdata_b_fwd),
    .match_a_i          (match_a),
    .match_b_i          (match_b),
    .mem_busy_i         (mem_busy),
    .outstanding_load_i (wb_info_i.outstanding_load),
    .lsu_req_done_i     (lsu_req_done_i),
    .ex_req_o           (ex_req_o),
    .id_in_ready_o      (id_in_ready_o),
    .illegal_insn_o     (illegal_insn_o)
  );

endmodule

/* sources.f */
+incdir+design
+incdir+test
design/id_isa_pkg.sv
design/id_pipe_pkg.sv
design/id_decoder.sv
design/id_rf_fwd.sv
design/id_issue_ctrl.sv
design/id_stage.sv
test/tb_id_stage.sv

/* test/tb_id_ref.svh */
`ifndef TB_ID_REF_SVH
`define TB_ID_REF_SVH

////////////////////////////////////////
// Register file model
////////////////////////////////////////

// Each register holds a pattern built from its own address
function automatic logic [`ID_XLEN-1:0] rf_model(input logic [`ID_REG_AW-1:0] addr);
  if (addr == '0) begin
    return '0;
  end
  return {addr, 3'b101, 8'hC3, addr, 3'b010, 8'h5A};
endfunction

// Value after the writeback bypass, x0 is never replaced
function automatic logic [`ID_XLEN-1:0] fwd_value(input logic [`ID_REG_AW-1:0] addr,
                                                  input wb_info_t wb);
  if (wb.write && addr != '0 && addr == wb.waddr) begin
    return wb.wdata;
  end
  return rf_model(addr);
endfunction

////////////////////////////////////////
// Expected decode
////////////////////////////////////////

// RV32I encodings limited to OP, OP-IMM, LUI, AUIPC, LOAD and STORE
function automatic logic ref_illegal(input logic [`ID_XLEN-1:0] instr);
  logic [2:0] f3;
  logic [6:0] f7;
  f3 = instr[14:12];
  f7 = instr[31:25];
  case (instr[6:0])
    OPCODE_OP:     return !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
    OPCODE_OP_IMM: begin
      if (f3 == 3'd1) return f7 != 7'h00;
      if (f3 == 3'd5) return !(f7 == 7'h00 || f7 == 7'h20);
      return 1'b0;
    end
    OPCODE_LUI, OPCODE_AUIPC: return 1'b0;
    // No LD, LWU or wider
    OPCODE_LOAD:   return f3 == 3'd3 || f3 >= 3'd6;
    OPCODE_STORE:  return f3 > 3'd2;
    default:       return 1'b1;
  endcase
endfunction

function automatic alu_op_e ref_alu_op(input logic [6:0] op, input logic [2:0] f3,
                                       input logic [6:0] f7);
  // Address and upper immediate math is a plain add
  if (op != OPCODE_OP && op != OPCODE_OP_IMM) return ALU_ADD;
  case (f3)
    3'd0:    return (op == OPCODE_OP && f7[5]) ? ALU_SUB : ALU_ADD;
    3'd1:    return ALU_SLL;
    3'd2:    return ALU_SLT;
    3'd3:    return ALU_SLTU;
    3'd4:    return ALU_XOR;
    3'd5:    return f7[5] ? ALU_SRA : ALU_SRL;
    3'd6:    return ALU_OR;
    default: return ALU_AND;
  endcase
endfunction

// Request of a legal instruction in its completing cycle
function automatic ex_req_t ref_req(input logic [`ID_XLEN-1:0] instr,
                                    input logic [`ID_XLEN-1:0] addr, input wb_info_t wb);
  ex_req_t             r;
  logic [6:0]          op;
  logic [2:0]          f3;
  logic [`ID_XLEN-1:0] imm_i;
  logic [`ID_XLEN-1:0] imm_s;
  logic [`ID_XLEN-1:0] imm_u;
  op    = instr[6:0];
  f3    = instr[14:12];
  imm_i = {{(`ID_XLEN-12){instr[31]}}, instr[31:20]};
  imm_s = {{(`ID_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
  imm_u = {instr[31:12], 12'h000};
  r           = '0;
  r.alu_op    = ref_alu_op(op, f3, instr[31:25]);
  r.operand_a = fwd_value(instr[19:15], wb);
  if (op == OPCODE_LUI) r.operand_a = '0;
  if (op == OPCODE_AUIPC) r.operand_a = addr;
  case (op)
    OPCODE_OP:                r.operand_b = fwd_value(instr[24:20], wb);
    OPCODE_STORE:             r.operand_b = imm_s;
    OPCODE_LUI, OPCODE_AUIPC: r.operand_b = imm_u;
    default:                  r.operand_b = imm_i;
  endcase
  // Every kept opcode but STORE writes rd
  r.rf_we        = op != OPCODE_STORE;
  r.rf_waddr     = instr[11:7];
  r.lsu_req      = op == OPCODE_LOAD || op == OPCODE_STORE;
  r.lsu_we       = op == OPCODE_STORE;
  r.lsu_type     = LSU_WORD;
  if (r.lsu_req && f3[1:0] == 2'b00) r.lsu_type = LSU_BYTE;
  if (r.lsu_req && f3[1:0] == 2'b01) r.lsu_type = LSU_HALF;
  r.lsu_sign_ext = op == OPCODE_LOAD && !f3[2];
  r.lsu_wdata    = fwd_value(instr[24:20], wb);
  return r;
endfunction

`endif

/* test/tb_id_stage.sv */
`timescale 1ns/100ps
`include "id_defines.svh"

module tb_id_stage;

  import id_isa_pkg::*;
  import id_pipe_pkg::*;

  localparam int TIMEOUT_CYCLES = 16;

  logic                  clk;
  logic                  rst_n;
  logic                  instr_valid;
  logic [`ID_XLEN-1:0]   instr_rdata;
  logic [`ID_XLEN-1:0]   pc;
  logic [`ID_REG_AW-1:0] rf_raddr_a;
  logic [`ID_REG_AW-1:0] rf_raddr_b;
  logic [`ID_XLEN-1:0]   rf_rdata_a;
  logic [`ID_XLEN-1:0]   rf_rdata_b;
  wb_info_t              wb_info;
  logic                  lsu_req_done;
  logic                  lsu_resp_valid;
  ex_req_t               ex_req;
  logic                  id_in_ready;
  logic                  illegal_insn;
  integer                seed = 38;
  string                 test_name;

  `include "tb_id_ref.svh"

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Register file answers from the address pattern
  assign rf_rdata_a = rf_model(rf_raddr_a);
  assign rf_rdata_b = rf_model(rf_raddr_b);

  id_stage dut_i (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .instr_valid_i    (instr_valid),
    .instr_rdata_i    (instr_rdata),
    .pc_i             (pc),
    .rf_raddr_a_o     (rf_raddr_a),
    .rf_raddr_b_o     (rf_raddr_b),
    .rf_rdata_a_i     (rf_rdata_a),
    .rf_rdata_b_i     (rf_rdata_b),
    .wb_info_i        (wb_info),
    .lsu_req_done_i   (lsu_req_done),
    .lsu_resp_valid_i (lsu_resp_valid),
    .ex_req_o         (ex_req),
    .id_in_ready_o    (id_in_ready),
    .illegal_insn_o   (illegal_insn)
  );

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("FAIL %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  // Every completing cycle is compared against the reference
  always @(negedge clk) begin
    if (rst_n && id_in_ready) begin
      if (ref_illegal(instr_rdata)) begin
        check_value({test_name, " illegal"}, 1, illegal_insn);
        check_value({test_name, " rf_we lsu_req"}, 0, {ex_req.rf_we, ex_req.lsu_req});
      end else begin
        check_value({test_name, " illegal"}, 0, illegal_insn);
        check_value({test_name, " request"}, ref_req(instr_rdata, pc, wb_info), ex_req);
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  function automatic logic [`ID_REG_AW-1:0] rand_reg();
    return $random(seed);
  endfunction

  function automatic logic [`ID_XLEN-1:0] rand_pc();
    return {$random(seed)} & 32'hFFFF_FFFC;
  endfunction

  task automatic present(input logic [`ID_XLEN-1:0] instr, input logic [`ID_XLEN-1:0] addr);
    instr_valid = 1'b1;
    instr_rdata = instr;
    pc          = addr;
  endtask

  // Drive point, shortly after the rising edge
  task automatic next_slot();
    @(posedge clk);
    #1;
  endtask

  task automatic single_cycle(input string name);
    @(negedge clk);
    check_value({name, " ready"}, 1, id_in_ready);
  endtask

  task automatic wait_done(input string name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (id_in_ready !== 1'b1) begin
      if (cycles >= TIMEOUT_CYCLES) begin
        abort_run($sformatf("Instruction in %s was not accepted within %0d cycles",
                            name, TIMEOUT_CYCLES));
      end else begin
        cycles++;
        @(negedge clk);
      end
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic drive_alu_ops();
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    test_name = "alu_decode";
    for (int n = 0; n < 24; n++) begin
      f3  = $random(seed);
      imm = $random(seed);
      if (n % 2 == 0) begin
        // SUB and SRA are the only funct7 variants
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && imm[0]) ? 7'h20 : 7'h00;
        present({f7, rand_reg(), rand_reg(), f3, rand_reg(), OPCODE_OP}, rand_pc());
      end else begin
        // Shift immediates keep bits 11:5 legal
        if (f3 == 3'd1) imm[11:5] = 7'h00;
        if (f3 == 3'd5) imm[11:5] = imm[11] ? 7'h20 : 7'h00;
        present({imm, rand_reg(), f3, rand_reg(), OPCODE_OP_IMM}, rand_pc());
      end
      single_cycle("alu_decode");
      next_slot();
    end
  endtask

  task automatic drive_upper_imm();
    logic [19:0]         uimm;
    logic [`ID_XLEN-1:0] addr;
    test_name = "upper_imm";
    for (int n = 0; n < 8; n++) begin
      uimm = $random(seed);
      addr = rand_pc();
      present({uimm, rand_reg(), n[0] ? OPCODE_AUIPC : OPCODE_LUI}, addr);
      single_cycle("upper_imm");
      check_value("upper_imm operand_a", n[0] ? addr : 32'h0, ex_req.operand_a);
      check_value("upper_imm operand_b", {uimm, 12'h000}, ex_req.operand_b);
      next_slot();
    end
  endtask

  task automatic check_forwarding();
    logic [`ID_XLEN-1:0] wdata;
    wdata     = $random(seed);
    test_name = "forwarding";
    // Writeback to x7 while x7 and x12 are read
    wb_info       = '0;
    wb_info.write = 1'b1;
    wb_info.waddr = 5'd7;
    wb_info.wdata = wdata;
    present({7'h00, 5'd12, 5'd7, 3'b000, 5'd3, OPCODE_OP}, 32'h100);
    single_cycle("forwarding");
    check_value("forwarding rs1 bypass", wdata, ex_req.operand_a);
    check_value("forwarding rs2 direct", rf_model(5'd12), ex_req.operand_b);
    next_slot();
    wb_info.waddr = 5'd12;
    single_cycle("forwarding");
    check_value("forwarding rs2 bypass", wdata, ex_req.operand_b);
    check_value("forwarding store data", wdata, ex_req.lsu_wdata);
    next_slot();
    // x0 target must be ignored
    wb_info.waddr = 5'd0;
    present({7'h00, 5'd0, 5'd0, 3'b000, 5'd5, OPCODE_OP}, 32'h104);
    single_cycle("forwarding");
    check_value("forwarding x0", 0, ex_req.operand_a);
    next_slot();
    wb_info.waddr = 5'd7;
    wb_info.write = 1'b0;
    present({7'h00, 5'd12, 5'd7, 3'b000, 5'd3, OPCODE_OP}, 32'h108);
    single_cycle("forwarding");
    check_value("forwarding write low", rf_model(5'd7), ex_req.operand_a);
    next_slot();
    wb_info = '0;
  endtask

  task automatic hold_on_load_use();
    test_name = "load_use";
    // Load to x9 in flight, next load uses x9 as base
    wb_info                  = '0;
    wb_info.waddr            = 5'd9;
    wb_info.outstanding_load = 1'b1;
    lsu_req_done             = 1'b1;
    // Response arrives, so memory is not busy and only the x9 match holds
    lsu_resp_valid           = 1'b1;
    present({12'h010, 5'd9, 3'b010, 5'd4, OPCODE_LOAD}, 32'h200);
    repeat (3) begin
      @(negedge clk);
      check_value("load_use stall ready", 0, id_in_ready);
      check_value("load_use stall lsu_req", 0, ex_req.lsu_req);
      next_slot();
    end
    // Load retired, a store still in flight blocks issue
    wb_info.outstanding_load  = 1'b0;
    wb_info.outstanding_store = 1'b1;
    lsu_resp_valid            = 1'b0;
    @(negedge clk);
    check_value("load_use busy ready", 0, id_in_ready);
    check_value("load_use busy lsu_req", 0, ex_req.lsu_req);
    next_slot();
    wb_info.outstanding_store = 1'b0;
    wait_done("load_use");
    next_slot();
    lsu_req_done = 1'b0;
  endtask

  task automatic sweep_mem_ops();
    logic [2:0]  f3;
    logic [11:0] imm;
    int          delay;
    test_name = "load_store";
    for (int n = 0; n < 12; n++) begin
      imm   = $random(seed);
      delay = {$random(seed)} % 4;
      if (n % 2 == 0) begin
        // LB LH LW LBU LHU
        f3 = {$random(seed)} % 6;
        if (f3 == 3'd3) f3 = 3'd2;
        present({imm, rand_reg(), f3, rand_reg(), OPCODE_LOAD}, rand_pc());
      end else begin
        f3 = {$random(seed)} % 3;
        present({imm[11:5], rand_reg(), rand_reg(), f3, imm[4:0], OPCODE_STORE}, rand_pc());
      end
      lsu_req_done = (delay == 0);
      // LSU holds off a random number of cycles
      for (int c = 0; c < delay; c++) begin
        @(negedge clk);
        check_value("load_store pending lsu_req", 1, ex_req.lsu_req);
        check_value("load_store pending ready", 0, id_in_ready);
        next_slot();
      end
      lsu_req_done = 1'b1;
      wait_done("load_store");
      next_slot();
      lsu_req_done = 1'b0;
    end
  endtask

  task automatic inject_illegal();
    logic [`ID_XLEN-1:0] bad[$];
    test_name = "illegal";
    // JAL, BRANCH, SYSTEM and MISC-MEM
    bad.push_back({25'h12_3456, 7'h6F});
    bad.push_back({25'h00_8A13, 7'h63});
    bad.push_back({25'h00_0000, 7'h73});
    bad.push_back({25'h00_0000, 7'h0F});
    // MUL, bad SLL funct7, bad SLLI, LD, SD
    bad.push_back({7'h01, 5'd2, 5'd1, 3'b000, 5'd3, OPCODE_OP});
    bad.push_back({7'h20, 5'd2, 5'd1, 3'b001, 5'd3, OPCODE_OP});
    bad.push_back({7'h20, 5'd2, 5'd1, 3'b001, 5'd3, OPCODE_OP_IMM});
    bad.push_back({12'h004, 5'd1, 3'b011, 5'd3, OPCODE_LOAD});
    bad.push_back({7'h00, 5'd2, 5'd1, 3'b011, 5'd0, OPCODE_STORE});
    foreach (bad[i]) begin
      present(bad[i], 32'h300 + 4 * i);
      single_cycle("illegal");
      check_value("illegal flag", 1, illegal_insn);
      next_slot();
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst_n          = 1'b0;
    instr_valid    = 1'b0;
    instr_rdata    = '0;
    pc             = '0;
    wb_info        = '0;
    lsu_req_done   = 1'b0;
    lsu_resp_valid = 1'b0;
    test_name      = "reset";
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("reset ready", 0, id_in_ready);
    check_value("reset rf_we", 0, ex_req.rf_we);
    check_value("reset lsu_req", 0, ex_req.lsu_req);
    next_slot();
    drive_alu_ops();
    drive_upper_imm();
    check_forwarding();
    hold_on_load_use();
    sweep_mem_ops();
    inject_illegal();
    instr_valid = 1'b0;
    next_slot();
    $display("All checks passed");
    $finish;
  end

endmodule
